// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Address and instruction geometry
    localparam int ADDR_W      = 16;
    localparam int INSTR_W     = 32;
    localparam int LINE_WORDS  = 4;
    localparam int LINE_OFS_W  = 2;
    localparam int BYTE_OFS_W  = 2;
    localparam int ID_W        = 4;
    localparam int LINE_W      = INSTR_W * LINE_WORDS;
    localparam int LINE_ADDR_W = ADDR_W - LINE_OFS_W - BYTE_OFS_W;

    // Memory tag field, wide enough for up to 16 entries
    localparam int TAG_W = 4;

    typedef logic [ADDR_W-1:0]      t_addr;
    typedef logic [LINE_ADDR_W-1:0] t_line_addr;
    typedef logic [ID_W-1:0]        t_fetch_id;
    typedef logic [LINE_OFS_W-1:0]  t_word_ofs;
    typedef logic [TAG_W-1:0]       t_mem_tag;

    // One line, seen flat for storage or as separate words for selection
    typedef union packed {
        logic [LINE_W-1:0]                   flat;
        logic [LINE_WORDS-1:0][INSTR_W-1:0]  words;
    } t_line;

    typedef struct packed {
        logic      valid;
        t_fetch_id id;
        t_addr     addr;
    } t_fetch_req;

    typedef struct packed {
        logic               valid;
        t_fetch_id          id;
        t_addr              pc;
        logic [INSTR_W-1:0] instr;
    } t_fetch_rsp;

    typedef struct packed {
        logic       valid;
        t_mem_tag   tag;
        t_line_addr line_addr;
    } t_mem_req;

    typedef struct packed {
        logic     valid;
        t_mem_tag tag;
        t_line    data;
    } t_mem_rsp;

    typedef struct packed {
        logic       valid;
        t_line_addr line_addr;
        t_line      data;
    } t_mem_load;

    // Request held by a miss entry; pf marks a fill with no response
    typedef struct packed {
        t_fetch_req req;
        logic       pf;
    } t_ent_info;

    function automatic t_line_addr line_of(t_addr a);
        return a[ADDR_W-1:LINE_OFS_W+BYTE_OFS_W];
    endfunction

    function automatic t_word_ofs word_of(t_addr a);
        return a[LINE_OFS_W+BYTE_OFS_W-1:BYTE_OFS_W];
    endfunction

    function automatic t_addr addr_of_line(t_line_addr l);
        return {l, {(LINE_OFS_W+BYTE_OFS_W){1'b0}}};
    endfunction

endpackage

`default_nettype wire

// File: hw/fb_entry.sv
`timescale 1ns/1ps
`default_nettype none

module fb_entry (
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  push,
    input  wire fetch_pkg::t_ent_info  push_info,
    output logic                       valid,
    output fetch_pkg::t_ent_info       info,

    output logic                       mem_req_rq,
    input  wire logic                  mem_req_gn,
    input  wire logic                  mem_rsp_hit,
    input  wire fetch_pkg::t_line      rsp_line,

    output logic                       fe_rsp_rq,
    input  wire logic                  fe_rsp_gn,
    output fetch_pkg::t_fetch_rsp      fe_rsp
);

    typedef enum logic [1:0] {
        ST_FREE,
        ST_REQ,
        ST_WAIT,
        ST_DLV
    } t_state;

    t_state           state;
    fetch_pkg::t_line line_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FREE;
        end else begin
            case (state)
                ST_FREE: if (push) state <= ST_REQ;
                ST_REQ:  if (mem_req_gn) state <= ST_WAIT;
                // Prefetch fills only update the buffer
                ST_WAIT: if (mem_rsp_hit) state <= info.pf ? ST_FREE : ST_DLV;
                ST_DLV:  if (fe_rsp_gn) state <= ST_FREE;
                default: state <= ST_FREE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (push && state == ST_FREE) begin
            info <= push_info;
        end
        if (mem_rsp_hit) begin
            line_q <= rsp_line;
        end
    end

    assign valid      = (state != ST_FREE);
    assign mem_req_rq = (state == ST_REQ);
    assign fe_rsp_rq  = (state == ST_DLV);

    always_comb begin
        fe_rsp       = '0;
        fe_rsp.valid = fe_rsp_rq;
        fe_rsp.id    = info.req.id;
        fe_rsp.pc    = info.req.addr;
        fe_rsp.instr = line_q.words[fetch_pkg::word_of(info.req.addr)];
    end

    // Allocation in fetch_buf must pick a free entry
    a_push_free: assert property (@(posedge clk) disable iff (reset) push |-> !valid)
        else $error("push to busy entry");

    // Line memory tags must only return to entries with a read in flight
    a_rsp_in_wait: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_hit |-> state == ST_WAIT)
        else $error("memory response outside wait state");

endmodule

`default_nettype wire

// File: hw/next_line_pf.sv
`timescale 1ns/1ps
`default_nettype none

module next_line_pf (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire fetch_pkg::t_fetch_req  fetch_req,
    output logic                        pf_rq,
    output fetch_pkg::t_line_addr       pf_line,
    input  wire logic                   pf_gn
);

    fetch_pkg::t_line_addr next_line;

    // Next line address wraps at the top
    assign next_line = fetch_pkg::line_of(fetch_req.addr) + 1'b1;

    // A newer demand request replaces a pending proposal
    always_ff @(posedge clk) begin
        if (reset) begin
            pf_rq <= 1'b0;
        end else if (fetch_req.valid) begin
            pf_rq <= 1'b1;
        end else if (pf_gn) begin
            pf_rq <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req.valid) begin
            pf_line <= next_line;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_buf.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buf #(
    parameter int NUM_SETS = 8,
    parameter int NUM_ENTS = 4
) (
    input  wire logic                   clk,
    input  wire logic                   reset,

    // Front end
    input  wire fetch_pkg::t_fetch_req  fetch_req,
    output logic                        fetch_ready,
    output fetch_pkg::t_fetch_rsp       fetch_rsp,

    // Line memory
    output fetch_pkg::t_mem_req         mem_req,
    input  wire fetch_pkg::t_mem_rsp    mem_rsp
);

    localparam int ENT_W = (NUM_ENTS > 1) ? $clog2(NUM_ENTS) : 1;
    localparam int SET_W = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1;

    typedef struct packed {
        logic                  valid;
        fetch_pkg::t_line_addr line_addr;
        fetch_pkg::t_line      data;
    } t_set;

    function automatic logic [NUM_ENTS-1:0] first_one(logic [NUM_ENTS-1:0] v);
        logic [NUM_ENTS-1:0] oh;
        logic                found;
        oh    = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_ENTS; i++) begin
            if (v[i] && !found) begin
                oh[i] = 1'b1;
                found = 1'b1;
            end
        end
        return oh;
    endfunction

    function automatic logic [ENT_W-1:0] encode(logic [NUM_ENTS-1:0] oh);
        logic [ENT_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < NUM_ENTS; i++) begin
            if (oh[i]) idx |= ENT_W'(i);
        end
        return idx;
    endfunction

    function automatic logic [SET_W-1:0] set_of(fetch_pkg::t_line_addr l);
        return SET_W'(l % NUM_SETS);
    endfunction

    t_set sets [NUM_SETS];

    fetch_pkg::t_line_addr req_line;
    t_set                  req_set;
    logic                  req_hit;
    logic                  req_miss;

    logic                  pf_rq;
    logic                  pf_gn;
    logic                  pf_push;
    logic                  pf_cover;
    logic                  pf_present;
    fetch_pkg::t_line_addr pf_line;
    t_set                  pf_set;

    logic [NUM_ENTS-1:0]   ent_valid;
    logic [NUM_ENTS-1:0]   ent_push;
    fetch_pkg::t_ent_info  ent_info [NUM_ENTS];
    fetch_pkg::t_ent_info  push_info;
    logic [NUM_ENTS-1:0]   ent_mem_rq;
    logic [NUM_ENTS-1:0]   ent_mem_gn;
    logic [NUM_ENTS-1:0]   ent_rsp_hit;
    logic [NUM_ENTS-1:0]   ent_fe_rq;
    logic [NUM_ENTS-1:0]   ent_fe_gn;
    fetch_pkg::t_fetch_rsp ent_fe_rsp [NUM_ENTS];

    logic [ENT_W-1:0]      mem_sel;
    logic [ENT_W-1:0]      fe_sel;
    logic [ENT_W-1:0]      rsp_sel;
    fetch_pkg::t_line_addr fill_line;
    fetch_pkg::t_fetch_rsp rsp_nxt;

    // Hit check
    assign req_line = fetch_pkg::line_of(fetch_req.addr);
    assign req_set  = sets[set_of(req_line)];
    assign req_hit  = fetch_req.valid && req_set.valid && req_set.line_addr == req_line;
    assign req_miss = fetch_req.valid && !req_hit;

    // Prefetch is dropped if the line is in flight or already buffered
    assign pf_set     = sets[set_of(pf_line)];
    assign pf_present = pf_set.valid && pf_set.line_addr == pf_line;
    always_comb begin
        pf_cover = 1'b0;
        for (int i = 0; i < NUM_ENTS; i++) begin
            if (ent_valid[i] && fetch_pkg::line_of(ent_info[i].req.addr) == pf_line) begin
                pf_cover = 1'b1;
            end
        end
    end

    assign fetch_ready = !(&ent_valid);
    assign pf_gn       = pf_rq && !req_miss && fetch_ready;
    assign pf_push     = pf_gn && !pf_cover && !pf_present;
    assign ent_push    = (req_miss || pf_push) ? first_one(~ent_valid) : '0;

    always_comb begin
        push_info          = '0;
        push_info.req      = fetch_req;
        push_info.pf       = 1'b0;
        if (!req_miss) begin
            push_info.req.valid = 1'b1;
            push_info.req.addr  = fetch_pkg::addr_of_line(pf_line);
            push_info.pf        = 1'b1;
        end
    end

    next_line_pf next_line_pf_u (
        .clk      (clk),
        .reset    (reset),
        .fetch_req(fetch_req),
        .pf_rq    (pf_rq),
        .pf_line  (pf_line),
        .pf_gn    (pf_gn)
    );

    for (genvar i = 0; i < NUM_ENTS; i++) begin : g_ent
        assign ent_rsp_hit[i] = mem_rsp.valid && mem_rsp.tag == fetch_pkg::TAG_W'(i);

        fb_entry fb_entry_u (
            .clk        (clk),
            .reset      (reset),
            .push       (ent_push[i]),
            .push_info  (push_info),
            .valid      (ent_valid[i]),
            .info       (ent_info[i]),
            .mem_req_rq (ent_mem_rq[i]),
            .mem_req_gn (ent_mem_gn[i]),
            .mem_rsp_hit(ent_rsp_hit[i]),
            .rsp_line   (mem_rsp.data),
            .fe_rsp_rq  (ent_fe_rq[i]),
            .fe_rsp_gn  (ent_fe_gn[i]),
            .fe_rsp     (ent_fe_rsp[i])
        );
    end

    // Memory request, lowest index first
    assign ent_mem_gn = first_one(ent_mem_rq);
    assign mem_sel    = encode(ent_mem_gn);
    always_comb begin
        mem_req           = '0;
        mem_req.valid     = |ent_mem_rq;
        mem_req.tag       = fetch_pkg::TAG_W'(mem_sel);
        mem_req.line_addr = fetch_pkg::line_of(ent_info[mem_sel].req.addr);
    end

    // Fill on every returning line
    assign rsp_sel   = mem_rsp.tag[ENT_W-1:0];
    assign fill_line = fetch_pkg::line_of(ent_info[rsp_sel].req.addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                sets[s].valid <= 1'b0;
            end
        end else if (mem_rsp.valid) begin
            sets[set_of(fill_line)].valid     <= 1'b1;
            sets[set_of(fill_line)].line_addr <= fill_line;
            sets[set_of(fill_line)].data      <= mem_rsp.data;
        end
    end

    // Hits win the response slot over entry delivery
    assign ent_fe_gn = req_hit ? '0 : first_one(ent_fe_rq);
    assign fe_sel    = encode(ent_fe_gn);

    always_comb begin
        rsp_nxt = '0;
        if (req_hit) begin
            rsp_nxt.valid = 1'b1;
            rsp_nxt.id    = fetch_req.id;
            rsp_nxt.pc    = fetch_req.addr;
            rsp_nxt.instr = req_set.data.words[fetch_pkg::word_of(fetch_req.addr)];
        end else if (|ent_fe_rq) begin
            rsp_nxt = ent_fe_rsp[fe_sel];
        end
    end

    always_ff @(posedge clk) begin
        fetch_rsp <= rsp_nxt;
        if (reset) begin
            fetch_rsp.valid <= 1'b0;
        end
    end

    // Front end must hold off while every entry is busy
    a_req_ready: assert property (@(posedge clk) disable iff (reset)
        fetch_req.valid |-> fetch_ready)
        else $error("fetch request while not ready");

endmodule

`default_nettype wire

// File: hw/line_mem.sv
`timescale 1ns/1ps
`default_nettype none

module line_mem #(
    parameter int MEM_LINES = 256,
    parameter int MEM_LAT   = 3
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire fetch_pkg::t_mem_load  mem_load,
    input  wire fetch_pkg::t_mem_req   mem_req,
    output fetch_pkg::t_mem_rsp        mem_rsp
);

    localparam int IDX_W = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;

    logic [fetch_pkg::LINE_W-1:0] mem [MEM_LINES];

    logic [IDX_W-1:0]       load_idx;
    logic [IDX_W-1:0]       rd_idx;
    fetch_pkg::t_mem_rsp    pipe [MEM_LAT];

    // Line address wraps onto the array
    assign load_idx = IDX_W'(mem_load.line_addr % MEM_LINES);
    assign rd_idx   = IDX_W'(mem_req.line_addr % MEM_LINES);

    always_ff @(posedge clk) begin
        if (mem_load.valid) begin
            mem[load_idx] <= mem_load.data.flat;
        end
    end

    // A load in the same cycle is not seen by the first read stage
    always_ff @(posedge clk) begin
        pipe[0].tag       <= mem_req.tag;
        pipe[0].data.flat <= mem[rd_idx];
        for (int i = 1; i < MEM_LAT; i++) begin
            pipe[i].tag  <= pipe[i-1].tag;
            pipe[i].data <= pipe[i-1].data;
        end
        // Valid bits of the read pipeline
        if (reset) begin
            for (int i = 0; i < MEM_LAT; i++) begin
                pipe[i].valid <= 1'b0;
            end
        end else begin
            pipe[0].valid <= mem_req.valid;
            for (int i = 1; i < MEM_LAT; i++) begin
                pipe[i].valid <= pipe[i-1].valid;
            end
        end
    end

    assign mem_rsp = pipe[MEM_LAT-1];

    // Loads are only expected while the fetch path is quiet
    a_load_idle: assert property (@(posedge clk) disable iff (reset)
        mem_load.valid |-> !mem_req.valid)
        else $error("memory load during fetch traffic");

endmodule

`default_nettype wire

// File: hw/fetch_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys #(
    parameter int NUM_SETS  = 8,
    parameter int NUM_ENTS  = 4,
    parameter int MEM_LINES = 256,
    parameter int MEM_LAT   = 3
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire fetch_pkg::t_fetch_req  fetch_req,
    output logic                        fetch_ready,
    output fetch_pkg::t_fetch_rsp       fetch_rsp,
    input  wire fetch_pkg::t_mem_load   mem_load
);

    // Buffer to memory link
    fetch_pkg::t_mem_req mem_req;
    fetch_pkg::t_mem_rsp mem_rsp;

    fetch_buf #(
        .NUM_SETS(NUM_SETS),
        .NUM_ENTS(NUM_ENTS)
    ) fetch_buf_u (
        .clk        (clk),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .fetch_ready(fetch_ready),
        .fetch_rsp  (fetch_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    line_mem #(
        .MEM_LINES(MEM_LINES),
        .MEM_LAT  (MEM_LAT)
    ) line_mem_u (
        .clk     (clk),
        .reset   (reset),
        .mem_load(mem_load),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

// File: verification/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter real PERIOD = 4.0
) (
    output logic clk
);

    // Free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2.0);
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: verification/fetch_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_tb;

    localparam int  NUM_SETS     = 8;
    localparam int  NUM_ENTS     = 4;
    localparam int  MEM_LINES    = 256;
    localparam int  MEM_LAT      = 3;
    localparam int  IDX_W        = $clog2(MEM_LINES);
    localparam int  NUM_IDS      = 1 << fetch_pkg::ID_W;
    localparam real CLK_PERIOD   = 4.0;
    localparam int  NUM_TESTS    = 5;
    localparam int  LOAD_LINES   = 32;
    localparam int  WAIT_LIMIT   = 200;
    localparam int  DRAIN_CYCLES = 16;

    logic                  clk;
    logic                  reset;
    fetch_pkg::t_fetch_req fetch_req;
    logic                  fetch_ready;
    fetch_pkg::t_fetch_rsp fetch_rsp;
    fetch_pkg::t_mem_load  mem_load;

    // Reference model state
    logic [fetch_pkg::LINE_W-1:0] shadow [MEM_LINES];
    fetch_pkg::t_addr             exp_addr [NUM_IDS];
    logic                         pending [NUM_IDS] = '{default: 1'b0};
    int                           req_cycle [NUM_IDS] = '{default: 0};
    int                           rsp_cycle [NUM_IDS] = '{default: 0};
    int outstanding  = 0;
    int cycle        = 0;
    int errors       = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int seed;

    tb_clkgen #(.PERIOD(CLK_PERIOD)) tb_clkgen_i (.clk(clk));

    fetch_subsys #(
        .NUM_SETS (NUM_SETS),
        .NUM_ENTS (NUM_ENTS),
        .MEM_LINES(MEM_LINES),
        .MEM_LAT  (MEM_LAT)
    ) fetch_subsys_i (
        .clk        (clk),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .fetch_ready(fetch_ready),
        .fetch_rsp  (fetch_rsp),
        .mem_load   (mem_load)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic fetch_pkg::t_addr make_addr(input int line_idx, input int word);
        return {fetch_pkg::t_line_addr'(line_idx), 2'(word), 2'b00};
    endfunction

    // Word at the address offset, word 0 in the low bits of the line
    function automatic logic [31:0] expected_instr(input fetch_pkg::t_addr addr);
        logic [IDX_W-1:0] idx;
        idx = IDX_W'(int'(addr[15:4]) % MEM_LINES);
        return shadow[idx][int'(addr[3:2]) * 32 +: 32];
    endfunction

    task automatic check_eq(input string name, input logic [127:0] expected,
                            input logic [127:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Response checker, matched by id
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && fetch_rsp.valid === 1'b1) begin
                if (!pending[fetch_rsp.id]) begin
                    $display("Error at %0t ns: response id %0d with no request waiting",
                             $time, fetch_rsp.id);
                    errors++;
                end else begin
                    check_eq("fetch_rsp.pc", 128'(exp_addr[fetch_rsp.id]), 128'(fetch_rsp.pc));
                    check_eq("fetch_rsp.instr", 128'(expected_instr(exp_addr[fetch_rsp.id])),
                             128'(fetch_rsp.instr));
                    rsp_cycle[fetch_rsp.id] = cycle;
                    pending[fetch_rsp.id]   = 1'b0;
                    outstanding--;
                end
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (fetch_ready !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
    endtask

    // One request strobe, sent once fetch_ready is high
    task automatic send_req(input fetch_pkg::t_fetch_id id, input fetch_pkg::t_addr addr);
        wait_ready();
        if (fetch_ready !== 1'b1) begin
            $display("Error at %0t ns: fetch_ready stuck low, id %0d not sent", $time, id);
            errors++;
        end else begin
            exp_addr[id]    = addr;
            pending[id]     = 1'b1;
            req_cycle[id]   = cycle;
            outstanding++;
            fetch_req.valid = 1'b1;
            fetch_req.id    = id;
            fetch_req.addr  = addr;
            @(negedge clk);
            fetch_req.valid = 1'b0;
        end
    endtask

    task automatic wait_rsps();
        int waited;
        waited = 0;
        while (outstanding > 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (outstanding > 0) begin
            $display("Error at %0t ns: %0d responses never arrived", $time, outstanding);
            errors++;
        end
    endtask

    task automatic check_hit(input fetch_pkg::t_fetch_id id);
        check_eq("hit latency", 128'(1), 128'(rsp_cycle[id] - req_cycle[id]));
    endtask

    task automatic check_miss(input fetch_pkg::t_fetch_id id);
        if (rsp_cycle[id] - req_cycle[id] <= 1) begin
            $display("Error at %0t ns: id %0d answered after %0d cycles, expected a miss",
                     $time, id, rsp_cycle[id] - req_cycle[id]);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        if (errors == errors_at_start) begin
            $display("Test %s: ok", name);
            tests_passed++;
        end else begin
            $display("Test %s: %0d errors", name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic test_reset_load();
        int           err0;
        logic [127:0] data;
        err0 = errors;
        check_eq("fetch_rsp.valid", 128'(0), 128'(fetch_rsp.valid));
        check_eq("fetch_ready", 128'(1), 128'(fetch_ready));
        for (int l = 0; l < LOAD_LINES; l++) begin
            data                = {$random(seed), $random(seed), $random(seed), $random(seed)};
            shadow[IDX_W'(l)]   = data;
            mem_load.valid      = 1'b1;
            mem_load.line_addr  = fetch_pkg::t_line_addr'(l);
            mem_load.data.flat  = data;
            @(negedge clk);
        end
        mem_load.valid = 1'b0;
        idle(4);
        check_eq("fetch_ready", 128'(1), 128'(fetch_ready));
        finish_test("reset_and_load", err0);
    endtask

    task automatic test_miss_then_hit();
        int err0;
        err0 = errors;
        send_req(4'd1, make_addr(3, 1));
        wait_rsps();
        check_miss(4'd1);
        send_req(4'd2, make_addr(3, 3));
        wait_rsps();
        check_hit(4'd2);
        idle(DRAIN_CYCLES);
        finish_test("miss_then_hit", err0);
    endtask

    // Four lines in four sets, back to back
    task automatic test_outstanding();
        int err0;
        err0 = errors;
        send_req(4'd4, make_addr(8, 0));
        send_req(4'd5, make_addr(10, 1));
        send_req(4'd6, make_addr(12, 2));
        send_req(4'd7, make_addr(14, 3));
        check_eq("fetch_ready", 128'(0), 128'(fetch_ready));
        wait_rsps();
        wait_ready();
        check_eq("fetch_ready", 128'(1), 128'(fetch_ready));
        idle(DRAIN_CYCLES);
        finish_test("outstanding_misses", err0);
    endtask

    task automatic test_prefetch();
        int err0;
        err0 = errors;
        send_req(4'd8, make_addr(20, 0));
        wait_rsps();
        check_miss(4'd8);
        idle(20);
        // Line 21 was brought in by the prefetcher
        send_req(4'd9, make_addr(21, 2));
        wait_rsps();
        check_hit(4'd9);
        idle(DRAIN_CYCLES);
        finish_test("prefetch", err0);
    endtask

    // Lines 24 and 16 share set 0
    task automatic test_conflict();
        int err0;
        err0 = errors;
        send_req(4'd10, make_addr(24, 1));
        wait_rsps();
        check_miss(4'd10);
        idle(DRAIN_CYCLES);
        send_req(4'd11, make_addr(16, 2));
        wait_rsps();
        check_miss(4'd11);
        idle(DRAIN_CYCLES);
        send_req(4'd12, make_addr(24, 3));
        wait_rsps();
        check_miss(4'd12);
        idle(DRAIN_CYCLES);
        finish_test("conflict_eviction", err0);
    endtask

    initial begin
        fetch_req = '0;
        mem_load  = '0;
        reset     = 1'b1;
        seed      = 72295;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        test_reset_load();
        test_miss_then_hit();
        test_outstanding();
        test_prefetch();
        test_conflict();
        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, 400 cycles per test
    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", NUM_TESTS * 400);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hw/fetch_pkg.sv
hw/fb_entry.sv
hw/next_line_pf.sv
hw/fetch_buf.sv
hw/line_mem.sv
hw/fetch_subsys.sv
verification/tb_clkgen.sv
verification/fetch_subsys_tb.sv

// File: Makefile
# Verilator flow for the fetch subsystem testbench
VERILATOR ?= verilator
TOP       ?= fetch_subsys_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Fails unless the run prints the pass message
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
